/* hdl/fetch_pkg.sv */
package fetch_pkg;

    // table geometry
    // one index bit picks user or machine code, the rest are word address bits
    localparam int INDEX_BITS = 5;
    localparam int TABLE_SIZE = 2 ** INDEX_BITS;

    // pipeline depth from fetch to execute compare
    localparam int EX_DEPTH = 2;

    // refill bubble after a redirect
    localparam int FLUSH_CYCLES = 2;
    localparam int FLUSH_CNT_BITS = $clog2(FLUSH_CYCLES + 1);
    localparam logic [FLUSH_CNT_BITS-1:0] FLUSH_LOAD = FLUSH_CNT_BITS'(FLUSH_CYCLES - 1);

    // first fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h1000_0000;

    // instruction class of the fetched word, as decoded upstream
    typedef enum logic [3:0] {
        alu    = 4'd0,
        load   = 4'd1,
        store  = 4'd2,
        jal    = 4'd3,
        jalr   = 4'd4,
        branch = 4'd5,
        other  = 4'd6
    } ir_type_e;

    // fetch control states
    typedef enum logic [1:0] {
        reset_vec = 2'd0,
        run       = 2'd1,
        flush     = 2'd2
    } fetch_state_e;

    // jal, jalr and branch all go through the predictor
    function automatic logic is_jump(input ir_type_e ir_type);
        return (ir_type == jal) || (ir_type == jalr) || (ir_type == branch);
    endfunction

    // pc[28] separates user code from machine code
    // pc[INDEX_BITS:2] is the low word address
    function automatic logic [INDEX_BITS-1:0] table_index(input logic [31:0] pc);
        return {pc[28], pc[INDEX_BITS:2]};
    endfunction

endpackage

/* hdl/jump_predictor.sv */
`timescale 1ns/1ps

module jump_predictor (
    input  logic                clk,
    input  logic                rst_n,

    // lookup side, from the fetch stage
    input  logic [31:0]         pc_if,
    input  fetch_pkg::ir_type_e ir_type_if,

    // rewrite side, from the execute compare
    input  logic                wr_en,
    input  logic [31:0]         wr_pc,
    input  logic                wr_taken,
    input  logic [31:0]         wr_target,

    // guess for the next fetch address
    output logic                pred_taken,
    output logic [31:0]         pred_next
);

    // per entry state
    // init says the target field holds a real address
    // taken is a 1-bit predictor
    logic [fetch_pkg::TABLE_SIZE-1:0] entry_init;
    logic [fetch_pkg::TABLE_SIZE-1:0] entry_taken;
    logic [31:0]                      entry_target [fetch_pkg::TABLE_SIZE];

    logic [fetch_pkg::INDEX_BITS-1:0] rd_index;
    logic [fetch_pkg::INDEX_BITS-1:0] wr_index;
    logic                             rd_is_jump;
    logic                             rd_hit;
    logic [31:0]                      pc_plus4;

    assign rd_index = fetch_pkg::table_index(pc_if);
    assign wr_index = fetch_pkg::table_index(wr_pc);
    assign rd_is_jump = fetch_pkg::is_jump(ir_type_if);
    assign pc_plus4 = pc_if + 32'd4;

    // combinational lookup
    // init gates taken so a never-written slot reads as not taken
    assign rd_hit = entry_init[rd_index] & entry_taken[rd_index];

    always_comb begin
        if (rd_is_jump && rd_hit) begin
            pred_taken = 1'b1;
            pred_next = entry_target[rd_index];
        end else begin
            // non-jumps and cold or not-taken entries fall through
            pred_taken = 1'b0;
            pred_next = pc_plus4;
        end
    end

    // init bits are the only control state in the table
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_init <= '0;
        end else if (wr_en) begin
            entry_init[wr_index] <= 1'b1;
        end
    end

    // state and target only change on a misprediction
    // a read in the write cycle still sees the old entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_taken[wr_index] <= wr_taken;
            entry_target[wr_index] <= wr_target;
        end
    end

endmodule

/* hdl/inflight_queue.sv */
`timescale 1ns/1ps

module inflight_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_valid,

    // what was fetched this cycle and how it was predicted
    input  logic [31:0]         pc_if,
    input  fetch_pkg::ir_type_e ir_type_if,
    input  logic                pred_taken,
    input  logic [31:0]         pred_next,

    // real outcome for the head instruction
    input  logic                ex_taken,
    input  logic [31:0]         ex_target,

    // redirect toward pc_gen and control
    output logic                mispredict,
    output logic [31:0]         correct_pc,

    // rewrite port of the predictor
    output logic                wr_en,
    output logic [31:0]         wr_pc,
    output logic                wr_taken,
    output logic [31:0]         wr_target
);

    // stage 0 is the youngest, stage EX_DEPTH-1 is the head at execute
    logic [fetch_pkg::EX_DEPTH-1:0] q_valid;
    logic [31:0]                    q_pc        [fetch_pkg::EX_DEPTH];
    fetch_pkg::ir_type_e            q_type      [fetch_pkg::EX_DEPTH];
    logic                           q_pred_tkn  [fetch_pkg::EX_DEPTH];
    logic [31:0]                    q_pred_next [fetch_pkg::EX_DEPTH];

    logic        head_valid;
    logic [31:0] head_pc;
    logic        head_jump;
    logic        dir_wrong;
    logic        tgt_wrong;

    assign head_valid = q_valid[fetch_pkg::EX_DEPTH-1];
    assign head_pc = q_pc[fetch_pkg::EX_DEPTH-1];
    assign head_jump = fetch_pkg::is_jump(q_type[fetch_pkg::EX_DEPTH-1]);

    // direction mismatch, or both taken but to different places
    assign dir_wrong = q_pred_tkn[fetch_pkg::EX_DEPTH-1] != ex_taken;
    assign tgt_wrong = ex_taken && q_pred_tkn[fetch_pkg::EX_DEPTH-1]
                    && (q_pred_next[fetch_pkg::EX_DEPTH-1] != ex_target);

    // ex_taken means nothing for non-jumps
    assign mispredict = head_valid && head_jump && (dir_wrong || tgt_wrong);
    assign correct_pc = ex_taken ? ex_target : head_pc + 32'd4;

    // learn the real outcome only when the guess was wrong
    assign wr_en = mispredict;
    assign wr_pc = head_pc;
    assign wr_taken = ex_taken;
    assign wr_target = ex_target;

    // valid bits shift in fetch_valid
    // a mispredict also kills the wrong-path word fetched this cycle
    always_ff @(posedge clk) begin
        if (!rst_n || mispredict) begin
            q_valid <= '0;
        end else begin
            q_valid <= {q_valid[fetch_pkg::EX_DEPTH-2:0], fetch_valid};
        end
    end

    // payload just follows along, valid decides if it counts
    always_ff @(posedge clk) begin
        q_pc[0] <= pc_if;
        q_type[0] <= ir_type_if;
        q_pred_tkn[0] <= pred_taken;
        q_pred_next[0] <= pred_next;
        for (int i = 1; i < fetch_pkg::EX_DEPTH; i++) begin
            q_pc[i] <= q_pc[i-1];
            q_type[i] <= q_type[i-1];
            q_pred_tkn[i] <= q_pred_tkn[i-1];
            q_pred_next[i] <= q_pred_next[i-1];
        end
    end

endmodule

/* hdl/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fetch_valid,
    input  logic        mispredict,
    input  logic [31:0] pred_next,
    input  logic [31:0] correct_pc,
    output logic [31:0] pc_if
);

    // priority is reset, then redirect, then the prediction
    // bubble cycles hold the address so fetch restarts where the redirect pointed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_if <= fetch_pkg::RESET_PC;
        end else if (mispredict) begin
            pc_if <= correct_pc;
        end else if (fetch_valid) begin
            // one word per cycle along the predicted path
            pc_if <= pred_next;
        end
    end

endmodule

/* hdl/flush_timer.sv */
`timescale 1ns/1ps

module flush_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic flush_start,
    output logic flush_done
);

    logic [fetch_pkg::FLUSH_CNT_BITS-1:0] count;

    // load on the redirect edge, then count down to zero
    // the state machine sits in flush until the count reaches zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (flush_start) begin
            count <= fetch_pkg::FLUSH_LOAD;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // idle reads as done too, the fsm only looks at it in flush
    assign flush_done = (count == '0);

endmodule

/* hdl/fetch_ctrl_fsm.sv */
`timescale 1ns/1ps

module fetch_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic mispredict,
    input  logic flush_done,
    output logic fetch_valid,
    output logic flush_start
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e state_next;

    // a redirect only counts while running
    // the queue is empty in the other states anyway
    assign flush_start = (state == fetch_pkg::run) && mispredict;

    always_comb begin
        state_next = state;
        case (state)
            // one idle cycle so the first fetch sees a settled pc
            fetch_pkg::reset_vec: begin
                state_next = fetch_pkg::run;
            end
            fetch_pkg::run: begin
                if (flush_start) begin
                    state_next = fetch_pkg::flush;
                end
            end
            // wait out the refill bubble
            fetch_pkg::flush: begin
                if (flush_done) begin
                    state_next = fetch_pkg::run;
                end
            end
            default: begin
                state_next = fetch_pkg::reset_vec;
            end
        endcase
    end

    // fetch_valid is a flop so it lines up with state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fetch_pkg::reset_vec;
            fetch_valid <= 1'b0;
        end else begin
            state <= state_next;
            fetch_valid <= (state_next == fetch_pkg::run);
        end
    end

endmodule

/* hdl/fetch_predict_top.sv */
`timescale 1ns/1ps

module fetch_predict_top (
    input  logic                clk,
    input  logic                rst_n,

    // type of the word at pc_if
    input  fetch_pkg::ir_type_e ir_type_if,

    // outcome of the instruction at the queue head
    input  logic                ex_taken,
    input  logic [31:0]         ex_target,

    output logic [31:0]         pc_if,
    output logic                fetch_valid,
    output logic                redirect,
    output logic [31:0]         redirect_pc
);

    // prediction path
    logic        pred_taken;
    logic [31:0] pred_next;

    // table rewrite path
    logic        wr_en;
    logic [31:0] wr_pc;
    logic        wr_taken;
    logic [31:0] wr_target;

    // redirect and control
    logic        mispredict;
    logic [31:0] correct_pc;
    logic        flush_start;
    logic        flush_done;

    assign redirect = mispredict;
    assign redirect_pc = correct_pc;

    jump_predictor u_jump_predictor (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_if      (pc_if),
        .ir_type_if (ir_type_if),
        .wr_en      (wr_en),
        .wr_pc      (wr_pc),
        .wr_taken   (wr_taken),
        .wr_target  (wr_target),
        .pred_taken (pred_taken),
        .pred_next  (pred_next)
    );

    inflight_queue u_inflight_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .pc_if       (pc_if),
        .ir_type_if  (ir_type_if),
        .pred_taken  (pred_taken),
        .pred_next   (pred_next),
        .ex_taken    (ex_taken),
        .ex_target   (ex_target),
        .mispredict  (mispredict),
        .correct_pc  (correct_pc),
        .wr_en       (wr_en),
        .wr_pc       (wr_pc),
        .wr_taken    (wr_taken),
        .wr_target   (wr_target)
    );

    pc_gen u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .mispredict  (mispredict),
        .pred_next   (pred_next),
        .correct_pc  (correct_pc),
        .pc_if       (pc_if)
    );

    flush_timer u_flush_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_start (flush_start),
        .flush_done  (flush_done)
    );

    fetch_ctrl_fsm u_fetch_ctrl_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .mispredict  (mispredict),
        .flush_done  (flush_done),
        .fetch_valid (fetch_valid),
        .flush_start (flush_start)
    );

endmodule

/* test/fetch_predict_asserts.sv */
`timescale 1ns/1ps

module fetch_predict_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    mispredict,
    input logic                    fetch_valid,
    input fetch_pkg::fetch_state_e state
);

    // read back by the testbench top at the end of the run
    int fail_count = 0;

    // reset_vec cycle keeps fetch off and run turns it on one cycle later
    valid_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !fetch_valid ##1 fetch_valid)
        else begin
            fail_count++;
            $error("fetch_valid wrong around the reset_vec cycle after reset");
        end

    // refill bubble of exactly FLUSH_CYCLES before fetch resumes
    bubble_after_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        mispredict |=> !fetch_valid [*fetch_pkg::FLUSH_CYCLES] ##1 fetch_valid)
        else begin
            fail_count++;
            $error("refill bubble after a redirect has the wrong length");
        end

    // the queue is empty outside run so no redirect can come from there
    redirect_only_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        mispredict |-> state == fetch_pkg::run)
        else begin
            fail_count++;
            $error("redirect raised while the control machine was not in run");
        end

endmodule

bind fetch_ctrl_fsm fetch_predict_asserts u_fetch_predict_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .mispredict  (mispredict),
    .fetch_valid (fetch_valid),
    .state       (state)
);

/* test/fetch_predict_checker.sv */
`timescale 1ns/1ps

module fetch_predict_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::ir_type_e ir_type_if,
    input  logic                ex_taken,
    input  logic [31:0]         ex_target,
    input  logic [31:0]         pc_if,
    input  logic                fetch_valid,
    input  logic                redirect,
    input  logic [31:0]         redirect_pc,
    output int                  error_count,
    output int                  check_count
);

    localparam int H = fetch_pkg::EX_DEPTH - 1;

    // reference table, in-flight stages (H is the head) and control
    logic        t_init   [fetch_pkg::TABLE_SIZE];
    logic        t_taken  [fetch_pkg::TABLE_SIZE];
    logic [31:0] t_target [fetch_pkg::TABLE_SIZE];
    logic        s_valid  [fetch_pkg::EX_DEPTH];
    logic        s_jump   [fetch_pkg::EX_DEPTH];
    logic        s_ptkn   [fetch_pkg::EX_DEPTH];
    logic [31:0] s_pc     [fetch_pkg::EX_DEPTH];
    logic [31:0] s_pnext  [fetch_pkg::EX_DEPTH];
    logic [31:0] m_pc = fetch_pkg::RESET_PC;
    logic        m_fv = 1'b0;
    logic        m_mis;
    logic [31:0] m_fix;
    fetch_pkg::fetch_state_e m_state = fetch_pkg::reset_vec;
    int          bubble = 0;
    int          resets = 0;

    function automatic logic jump_kind(input fetch_pkg::ir_type_e t);
        return t inside {fetch_pkg::jal, fetch_pkg::jalr, fetch_pkg::branch};
    endfunction

    // bit 28 on top, word address bits below it
    function automatic int slot(input logic [31:0] pc);
        return (int'(pc[28]) << (fetch_pkg::INDEX_BITS - 1))
             | int'((pc >> 2) & (fetch_pkg::TABLE_SIZE / 2 - 1));
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // head outcome check, straight from the misprediction rule
    assign m_mis = s_valid[H] && s_jump[H]
                && ((s_ptkn[H] != ex_taken) || (ex_taken && s_pnext[H] != ex_target));
    assign m_fix = ex_taken ? ex_target : s_pc[H] + 32'd4;

    initial begin
        error_count = 0;
        check_count = 0;
        foreach (s_valid[i]) s_valid[i] = 1'b0;
    end

    always @(posedge clk) begin
        int          k;
        logic        mis;
        logic [31:0] fix;
        logic        p_tkn;
        logic [31:0] p_next;
        mis = m_mis;
        fix = m_fix;
        k = slot(m_pc);
        // guess made this cycle, against the table before any rewrite
        p_tkn = jump_kind(ir_type_if) && t_init[k] && t_taken[k];
        p_next = p_tkn ? t_target[k] : m_pc + 32'd4;
        if (mis && rst_n) begin
            k = slot(s_pc[H]);
            t_init[k] = 1'b1;
            t_taken[k] = ex_taken;
            t_target[k] = ex_target;
        end
        for (int i = H; i > 0; i--) begin
            s_valid[i] = s_valid[i-1] && !mis;
            s_jump[i] = s_jump[i-1];
            s_ptkn[i] = s_ptkn[i-1];
            s_pc[i] = s_pc[i-1];
            s_pnext[i] = s_pnext[i-1];
        end
        // younger wrong-path word dies with the redirect
        s_valid[0] = m_fv && !mis;
        s_jump[0] = jump_kind(ir_type_if);
        s_ptkn[0] = p_tkn;
        s_pc[0] = m_pc;
        s_pnext[0] = p_next;
        if (!rst_n) begin
            resets++;
            m_pc = fetch_pkg::RESET_PC;
            m_fv = 1'b0;
            m_state = fetch_pkg::reset_vec;
            foreach (t_init[i]) t_init[i] = 1'b0;
            foreach (s_valid[i]) s_valid[i] = 1'b0;
        end else if (mis) begin
            m_pc = fix;
            m_fv = 1'b0;
            m_state = fetch_pkg::flush;
            bubble = fetch_pkg::FLUSH_CYCLES;
        end else if (m_state == fetch_pkg::flush) begin
            // pc held through the bubble
            bubble--;
            if (bubble == 0) begin
                m_state = fetch_pkg::run;
                m_fv = 1'b1;
            end
        end else begin
            if (m_fv) begin
                m_pc = p_next;
            end
            m_state = fetch_pkg::run;
            m_fv = 1'b1;
        end
    end

    // mid-cycle, all outputs settled
    always @(negedge clk) begin
        if (resets > 0) begin
            compare("pc_if", m_pc, pc_if);
            compare("fetch_valid", m_fv, fetch_valid);
            compare("redirect", m_mis, redirect);
            if (m_mis) begin
                compare("redirect_pc", m_fix, redirect_pc);
            end
        end
    end

endmodule

/* test/fetch_predict_tb.sv */
`timescale 1ns/1ps

module fetch_predict_tb;

    localparam int CLK_HALF = 50;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 5;
    localparam int RUN_CYCLES = 2000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 100;
    localparam int KEYS = 512;

    // small landing set, loops stay near these
    // 0x1000_0000 and 0x0000_0000 differ only in bit 28
    // 0x1000_0080 and 0x1000_0100 share a slot with 0x1000_0000
    localparam logic [31:0] TARGETS [8] = '{
        32'h1000_0000, 32'h0000_0000, 32'h1000_0080, 32'h1000_0040,
        32'h0000_0040, 32'h1000_0100, 32'h1000_0018, 32'h0000_0018
    };

    logic                clk;
    logic                rst_n;
    fetch_pkg::ir_type_e ir_type_if;
    logic                ex_taken;
    logic [31:0]         ex_target;
    logic [31:0]         pc_if;
    logic                fetch_valid;
    logic                redirect;
    logic [31:0]         redirect_pc;
    int                  error_count;
    int                  check_count;
    int                  cycle_count = 0;

    // program image, one type and one repeating outcome per pc
    fetch_pkg::ir_type_e prog_type   [KEYS];
    logic                prog_taken  [KEYS];
    logic [31:0]         prog_target [KEYS];
    logic [31:0]         pc_hist     [fetch_pkg::EX_DEPTH+1];

    function automatic int image_key(input logic [31:0] pc);
        return int'({pc[28], pc[9:2]});
    endfunction

    // about half of the words are jumps
    task automatic build_program();
        int r;
        for (int k = 0; k < KEYS; k++) begin
            r = $urandom_range(9, 0);
            case (r)
                0, 1, 2: prog_type[k] = fetch_pkg::branch;
                3:       prog_type[k] = fetch_pkg::jal;
                4:       prog_type[k] = fetch_pkg::jalr;
                5, 6:    prog_type[k] = fetch_pkg::alu;
                7:       prog_type[k] = fetch_pkg::load;
                8:       prog_type[k] = fetch_pkg::store;
                default: prog_type[k] = fetch_pkg::other;
            endcase
            prog_taken[k] = (prog_type[k] == fetch_pkg::jal) ? 1'b1 : 1'($urandom_range(1, 0));
            prog_target[k] = TARGETS[$urandom_range(7, 0)];
        end
    endtask

    // type of the word at pc_if, outcome of the word fetched EX_DEPTH cycles ago
    task automatic drive_inputs();
        int head_key;
        for (int i = fetch_pkg::EX_DEPTH; i > 0; i--) begin
            pc_hist[i] = pc_hist[i-1];
        end
        pc_hist[0] = pc_if;
        head_key = image_key(pc_hist[fetch_pkg::EX_DEPTH]);
        ir_type_if = prog_type[image_key(pc_if)];
        ex_target = prog_target[head_key];
        if (prog_type[head_key] inside {fetch_pkg::jal, fetch_pkg::jalr, fetch_pkg::branch}) begin
            ex_taken = prog_taken[head_key];
        end else begin
            // noise, non-jumps must ignore it
            ex_taken = 1'($urandom_range(1, 0));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int assert_fails;
        void'($urandom(32'h2beb_e226));
        rst_n = 1'b0;
        ir_type_if = fetch_pkg::alu;
        ex_taken = 1'b0;
        ex_target = 32'h0;
        foreach (pc_hist[i]) pc_hist[i] = fetch_pkg::RESET_PC;
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        drive_inputs();
        repeat (RUN_CYCLES - 1) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            drive_inputs();
        end
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY);
        assert_fails = u_fetch_predict_top.u_fetch_ctrl_fsm.u_fetch_predict_asserts.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    fetch_predict_top u_fetch_predict_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .ir_type_if  (ir_type_if),
        .ex_taken    (ex_taken),
        .ex_target   (ex_target),
        .pc_if       (pc_if),
        .fetch_valid (fetch_valid),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    fetch_predict_checker u_fetch_predict_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .ir_type_if  (ir_type_if),
        .ex_taken    (ex_taken),
        .ex_target   (ex_target),
        .pc_if       (pc_if),
        .fetch_valid (fetch_valid),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .error_count (error_count),
        .check_count (check_count)
    );

endmodule

/* filelist.f */
hdl/fetch_pkg.sv
hdl/jump_predictor.sv
hdl/inflight_queue.sv
hdl/pc_gen.sv
hdl/flush_timer.sv
hdl/fetch_ctrl_fsm.sv
hdl/fetch_predict_top.sv
test/fetch_predict_asserts.sv
test/fetch_predict_checker.sv
test/fetch_predict_tb.sv
